// ==== all.f ====
verilog/cache_pkg.sv
verilog/req_stage.sv
verilog/refill_stage.sv
verilog/tag_data_array.sv
verilog/hit_miss_ctrl.sv
verilog/l1_ctrl_top.sv
bench/tb_clk_gen.sv
bench/tb_l1_ctrl.sv

// ==== Makefile ====
TOP := tb_l1_ctrl
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f \
		--Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_l1_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_l1_ctrl;
    import cache_pkg::*;

    localparam int NUM_RANDOM    = 2000;
    localparam int NUM_TIDS      = 1 << TID_W;
    localparam int SLOT_TIMEOUT  = 64;
    localparam int DRAIN_TIMEOUT = 500;

    typedef enum int {EXP_NONE, EXP_HIT, EXP_MISS, EXP_STORE, EXP_FILL} exp_kind_e;

    typedef struct packed {
        nline_t      nline;
        tid_t        tid;
        widx_t       word;
        int unsigned due;
    } miss_rec_t;

    logic   clk;
    logic   rst_n;

    logic   core_req_valid;
    logic   core_req_is_store;
    addr_t  core_req_addr;
    word_t  core_req_wdata;
    be_t    core_req_be;
    tid_t   core_req_tid;
    logic   core_rsp_valid;
    word_t  core_rsp_rdata;
    tid_t   core_rsp_tid;
    logic   miss_valid;
    nline_t miss_nline;
    tid_t   miss_tid;
    widx_t  miss_word;
    logic   refill_valid;
    nline_t refill_nline;
    tid_t   refill_tid;
    widx_t  refill_word;
    line_t  refill_line;
    logic   mem_write_valid;
    addr_t  mem_write_addr;
    word_t  mem_write_data;
    be_t    mem_write_be;

    // Memory model and directory shadow
    word_t       mem [addr_t];
    logic        dir_valid [NSETS];
    tag_t        dir_tag [NSETS];
    logic        pending [NUM_TIDS];
    addr_t       pending_addr [NUM_TIDS];
    miss_rec_t   miss_q [$];

    // What the cycle after the last drive must show
    exp_kind_e   exp_kind;
    tid_t        exp_tid;
    addr_t       exp_addr;
    word_t       exp_data;
    be_t         exp_be;

    int unsigned cycle_cnt;
    int          mismatch_cnt;
    int          timeout_cnt;
    int          loads_issued;
    int          rsp_cnt;
    tid_t        next_tid;

    tb_clk_gen clk_gen_i (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    l1_ctrl_top dut_i (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .core_req_valid_i    (core_req_valid),
        .core_req_is_store_i (core_req_is_store),
        .core_req_addr_i     (core_req_addr),
        .core_req_wdata_i    (core_req_wdata),
        .core_req_be_i       (core_req_be),
        .core_req_tid_i      (core_req_tid),
        .core_rsp_valid_o    (core_rsp_valid),
        .core_rsp_rdata_o    (core_rsp_rdata),
        .core_rsp_tid_o      (core_rsp_tid),
        .miss_valid_o        (miss_valid),
        .miss_nline_o        (miss_nline),
        .miss_tid_o          (miss_tid),
        .miss_word_o         (miss_word),
        .refill_valid_i      (refill_valid),
        .refill_nline_i      (refill_nline),
        .refill_tid_i        (refill_tid),
        .refill_word_i       (refill_word),
        .refill_line_i       (refill_line),
        .mem_write_valid_o   (mem_write_valid),
        .mem_write_addr_o    (mem_write_addr),
        .mem_write_data_o    (mem_write_data),
        .mem_write_be_o      (mem_write_be)
    );

    // Untouched memory words, every address bit mixed in
    function automatic word_t fill_pattern(addr_t waddr);
        return (waddr * 32'h9E37_79B1) ^ {waddr[15:0], waddr[31:16]} ^ 32'hC3A5_5A3C;
    endfunction

    function automatic addr_t word_addr(addr_t a);
        return {a[ADDR_W-1:BYTE_IDX_W], {BYTE_IDX_W{1'b0}}};
    endfunction

    // Expected load data, memory is the truth under write-through
    function automatic word_t ref_load_word(addr_t a);
        addr_t wa;
        wa = word_addr(a);
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return fill_pattern(wa);
    endfunction

    function automatic logic line_present(addr_t a);
        cache_addr_u ua;
        ua.addr = a;
        return dir_valid[ua.fields.set] && (dir_tag[ua.fields.set] == ua.fields.tag);
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        foreach (pending[i]) begin
            if (pending[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    // Small tag pool so sets see hits and replacements
    function automatic addr_t random_addr();
        cache_addr_u ua;
        ua.fields.tag      = tag_t'(24'h00_0C00 + $urandom_range(0, 3));
        ua.fields.set      = set_t'($urandom_range(0, NSETS - 1));
        ua.fields.word     = widx_t'($urandom_range(0, LINE_WORDS - 1));
        ua.fields.byte_idx = 2'($urandom_range(0, 3));
        return ua.addr;
    endfunction

    task automatic store_to_memory(addr_t a, word_t data, be_t be);
        word_t w;
        w = ref_load_word(a);
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        mem[word_addr(a)] = w;
    endtask

    task automatic flag_mismatch(string what);
        mismatch_cnt++;
        $display("** Error at time %0t: %s", $time, what);
    endtask

    task automatic finish_run();
        $display("Summary: %0d mismatches, %0d timeouts, %0d loads, %0d responses",
                 mismatch_cnt, timeout_cnt, loads_issued, rsp_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic give_up(string what);
        timeout_cnt++;
        $display("Timeout: %s", what);
        finish_run();
    endtask

    task automatic next_slot();
        @(negedge clk);
        core_req_valid = 1'b0;
        refill_valid   = 1'b0;
        exp_kind       = EXP_NONE;
    endtask

    // Returns the oldest due miss as a refill built from current memory
    task automatic try_refill(output logic sent);
        miss_rec_t   rec;
        cache_addr_u ua;
        int          idx;
        idx = -1;
        foreach (miss_q[i]) begin
            if (idx < 0 && miss_q[i].due <= cycle_cnt) begin
                idx = i;
            end
        end
        sent = (idx >= 0);
        if (sent) begin
            rec = miss_q[idx];
            miss_q.delete(idx);
            for (int w = 0; w < LINE_WORDS; w++) begin
                refill_line[w*WORD_W +: WORD_W] = ref_load_word({rec.nline, widx_t'(w), 2'b00});
            end
            refill_valid = 1'b1;
            refill_nline = rec.nline;
            refill_tid   = rec.tid;
            refill_word  = rec.word;
            ua.addr = {rec.nline, {(WORD_IDX_W + BYTE_IDX_W){1'b0}}};
            dir_valid[ua.fields.set] = 1'b1;
            dir_tag[ua.fields.set]   = ua.fields.tag;
            exp_kind = EXP_FILL;
            exp_tid  = rec.tid;
        end
    endtask

    task automatic idle_slot();
        logic sent;
        next_slot();
        try_refill(sent);
    endtask

    task automatic issue_request(logic is_store, addr_t a, word_t data, be_t be);
        logic sent;
        int   tries;
        tries = 0;
        do begin
            next_slot();
            try_refill(sent);
            tries++;
            if (tries > SLOT_TIMEOUT) begin
                give_up("refills kept the core request port busy");
            end
        end while (sent);
        core_req_valid    = 1'b1;
        core_req_is_store = is_store;
        core_req_addr     = a;
        core_req_wdata    = data;
        core_req_be       = be;
        exp_addr          = a;
        if (is_store) begin
            core_req_tid = tid_t'($urandom_range(0, NUM_TIDS - 1));
            store_to_memory(a, data, be);
            exp_kind = EXP_STORE;
            exp_data = data;
            exp_be   = be;
        end else begin
            core_req_tid          = next_tid;
            pending[next_tid]     = 1'b1;
            pending_addr[next_tid] = a;
            loads_issued++;
            exp_tid = next_tid;
            if (line_present(a)) begin
                exp_kind = EXP_HIT;
            end else begin
                exp_kind = EXP_MISS;
            end
            next_tid++;
        end
    endtask

    task automatic issue_load(addr_t a);
        int waited;
        waited = 0;
        while (pending[next_tid]) begin
            next_tid++;
            waited++;
            if (waited % NUM_TIDS == 0) begin
                idle_slot();
            end
            if (waited > NUM_TIDS * SLOT_TIMEOUT) begin
                give_up("no load tid became free");
            end
        end
        issue_request(1'b0, a, '0, '0);
    endtask

    task automatic wait_for_quiet();
        int waited;
        waited = 0;
        while (count_pending() != 0 || miss_q.size() != 0) begin
            idle_slot();
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                give_up("outstanding loads were never answered");
            end
        end
        idle_slot();
    endtask

    task automatic check_response();
        word_t want;
        assert (pending[core_rsp_tid])
            else flag_mismatch($sformatf("response tid %0d has no load outstanding",
                                         core_rsp_tid));
        assert (core_rsp_tid == exp_tid)
            else flag_mismatch($sformatf("response tid %0d, expected %0d",
                                         core_rsp_tid, exp_tid));
        if (pending[core_rsp_tid]) begin
            want = ref_load_word(pending_addr[core_rsp_tid]);
            assert (core_rsp_rdata == want)
                else flag_mismatch($sformatf("tid %0d addr %h read %h, expected %h",
                    core_rsp_tid, pending_addr[core_rsp_tid], core_rsp_rdata, want));
            pending[core_rsp_tid] = 1'b0;
        end
        rsp_cnt++;
    endtask

    task automatic check_miss();
        cache_addr_u ua;
        nline_t      want_nline;
        miss_rec_t   rec;
        ua.addr    = exp_addr;
        want_nline = exp_addr[ADDR_W-1:WORD_IDX_W+BYTE_IDX_W];
        assert (miss_nline == want_nline)
            else flag_mismatch($sformatf("miss line %h for addr %h", miss_nline, exp_addr));
        assert (miss_tid == exp_tid && miss_word == ua.fields.word)
            else flag_mismatch($sformatf("miss tid %0d word %0d, expected %0d word %0d",
                                         miss_tid, miss_word, exp_tid, ua.fields.word));
        rec.nline = want_nline;
        rec.tid   = exp_tid;
        rec.word  = ua.fields.word;
        rec.due   = cycle_cnt + $urandom_range(1, 8);
        miss_q.push_back(rec);
    endtask

    task automatic check_write();
        assert (mem_write_addr == exp_addr && mem_write_data == exp_data
                && mem_write_be == exp_be)
            else flag_mismatch($sformatf("write-through %h/%h/%b, expected %h/%h/%b",
                mem_write_addr, mem_write_data, mem_write_be, exp_addr, exp_data, exp_be));
    endtask

    // Outputs settle well after the rising edge
    always begin : compare_outputs
        logic want_rsp;
        @(posedge clk);
        #1;
        cycle_cnt++;
        want_rsp = (exp_kind == EXP_HIT) || (exp_kind == EXP_FILL);
        assert (core_rsp_valid === want_rsp)
            else flag_mismatch($sformatf("response strobe %b, expected %b",
                                         core_rsp_valid, want_rsp));
        if (core_rsp_valid === 1'b1) begin
            check_response();
        end
        assert (miss_valid === (exp_kind == EXP_MISS))
            else flag_mismatch($sformatf("miss strobe %b for %s", miss_valid, exp_kind.name()));
        if (miss_valid === 1'b1 && exp_kind == EXP_MISS) begin
            check_miss();
        end
        assert (mem_write_valid === (exp_kind == EXP_STORE))
            else flag_mismatch($sformatf("write-through strobe %b for %s",
                                         mem_write_valid, exp_kind.name()));
        if (mem_write_valid === 1'b1 && exp_kind == EXP_STORE) begin
            check_write();
        end
    end

    initial begin : run_test
        int unsigned seed;
        int          waited;
        addr_t       a;
        seed = $urandom(21);
        core_req_valid    = 1'b0;
        core_req_is_store = 1'b0;
        core_req_addr     = '0;
        core_req_wdata    = '0;
        core_req_be       = '0;
        core_req_tid      = '0;
        refill_valid      = 1'b0;
        refill_nline      = '0;
        refill_tid        = '0;
        refill_word       = '0;
        refill_line       = '0;
        foreach (pending[i]) begin
            pending[i] = 1'b0;
        end
        foreach (dir_valid[i]) begin
            dir_valid[i] = 1'b0;
        end
        exp_kind     = EXP_NONE;
        cycle_cnt    = 0;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        loads_issued = 0;
        rsp_cnt      = 0;
        next_tid     = '0;

        waited = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                give_up("reset was never released");
            end
        end

        // Cold miss, then hit, store hit and merged read back
        a = 32'h0001_2340;
        issue_load(a);
        wait_for_quiet();
        issue_load(a);
        issue_request(1'b1, a, 32'hDEAD_BEEF, 4'b0101);
        issue_load(a);
        // Store to an absent line must not allocate
        issue_request(1'b1, 32'h0004_5678, 32'h1234_5678, 4'b1111);
        issue_load(32'h0004_5678);
        wait_for_quiet();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            a = random_addr();
            if ($urandom_range(0, 2) == 0) begin
                issue_request(1'b1, a, $urandom, be_t'($urandom_range(1, 15)));
            end else begin
                issue_load(a);
            end
            if ($urandom_range(0, 3) == 0) begin
                idle_slot();
            end
        end
        wait_for_quiet();

        assert (loads_issued == rsp_cnt)
            else flag_mismatch($sformatf("%0d loads got %0d responses", loads_issued, rsp_cnt));
        finish_run();
    end

endmodule

`default_nettype wire

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_no
);
    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Release away from the rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/l1_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module l1_ctrl_top (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  logic                core_req_valid_i,
    input  logic                core_req_is_store_i,
    input  cache_pkg::addr_t    core_req_addr_i,
    input  cache_pkg::word_t    core_req_wdata_i,
    input  cache_pkg::be_t      core_req_be_i,
    input  cache_pkg::tid_t     core_req_tid_i,

    output logic                core_rsp_valid_o,
    output cache_pkg::word_t    core_rsp_rdata_o,
    output cache_pkg::tid_t     core_rsp_tid_o,

    output logic                miss_valid_o,
    output cache_pkg::nline_t   miss_nline_o,
    output cache_pkg::tid_t     miss_tid_o,
    output cache_pkg::widx_t    miss_word_o,

    input  logic                refill_valid_i,
    input  cache_pkg::nline_t   refill_nline_i,
    input  cache_pkg::tid_t     refill_tid_i,
    input  cache_pkg::widx_t    refill_word_i,
    input  cache_pkg::line_t    refill_line_i,

    output logic                mem_write_valid_o,
    output cache_pkg::addr_t    mem_write_addr_o,
    output cache_pkg::word_t    mem_write_data_o,
    output cache_pkg::be_t      mem_write_be_o
);
    import cache_pkg::*;

    // Stage 1 request
    logic        s1_valid;
    logic        s1_is_store;
    cache_addr_u s1_addr;
    word_t       s1_wdata;
    be_t         s1_be;
    tid_t        s1_tid;

    // Array lookup result
    logic        hit;
    word_t       rd_word;

    // Store word write
    logic        wr_en;
    be_t         wr_be;
    word_t       wr_data;

    // Registered refill
    logic        fill_valid;
    nline_t      fill_nline;
    line_t       fill_line;
    tid_t        fill_tid;
    word_t       fill_rdata;

    req_stage req_stage_i (
        .clk_i,
        .rst_ni,
        .core_req_valid_i,
        .core_req_is_store_i,
        .core_req_addr_i,
        .core_req_wdata_i,
        .core_req_be_i,
        .core_req_tid_i,
        .s1_valid_o    (s1_valid),
        .s1_is_store_o (s1_is_store),
        .s1_addr_o     (s1_addr),
        .s1_wdata_o    (s1_wdata),
        .s1_be_o       (s1_be),
        .s1_tid_o      (s1_tid)
    );

    refill_stage refill_stage_i (
        .clk_i,
        .rst_ni,
        .refill_valid_i,
        .refill_nline_i,
        .refill_tid_i,
        .refill_word_i,
        .refill_line_i,
        .core_req_valid_i,
        .fill_valid_o (fill_valid),
        .fill_nline_o (fill_nline),
        .fill_line_o  (fill_line),
        .fill_tid_o   (fill_tid),
        .fill_rdata_o (fill_rdata)
    );

    tag_data_array tag_data_array_i (
        .clk_i,
        .rst_ni,
        .rd_addr_i    (s1_addr),
        .wr_en_i      (wr_en),
        .wr_be_i      (wr_be),
        .wr_data_i    (wr_data),
        .fill_valid_i (fill_valid),
        .fill_nline_i (fill_nline),
        .fill_line_i  (fill_line),
        .hit_o        (hit),
        .rd_word_o    (rd_word)
    );

    hit_miss_ctrl hit_miss_ctrl_i (
        .clk_i,
        .rst_ni,
        .s1_valid_i    (s1_valid),
        .s1_is_store_i (s1_is_store),
        .s1_addr_i     (s1_addr),
        .s1_wdata_i    (s1_wdata),
        .s1_be_i       (s1_be),
        .s1_tid_i      (s1_tid),
        .hit_i         (hit),
        .rd_word_i     (rd_word),
        .fill_valid_i  (fill_valid),
        .fill_rdata_i  (fill_rdata),
        .fill_tid_i    (fill_tid),
        .wr_en_o       (wr_en),
        .wr_be_o       (wr_be),
        .wr_data_o     (wr_data),
        .core_rsp_valid_o,
        .core_rsp_rdata_o,
        .core_rsp_tid_o,
        .miss_valid_o,
        .miss_nline_o,
        .miss_tid_o,
        .miss_word_o,
        .mem_write_valid_o,
        .mem_write_addr_o,
        .mem_write_data_o,
        .mem_write_be_o
    );

endmodule

`default_nettype wire

// ==== verilog/hit_miss_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hit_miss_ctrl (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    input  logic                   s1_valid_i,
    input  logic                   s1_is_store_i,
    input  cache_pkg::cache_addr_u s1_addr_i,
    input  cache_pkg::word_t       s1_wdata_i,
    input  cache_pkg::be_t         s1_be_i,
    input  cache_pkg::tid_t        s1_tid_i,

    input  logic                   hit_i,
    input  cache_pkg::word_t       rd_word_i,

    input  logic                   fill_valid_i,
    input  cache_pkg::word_t       fill_rdata_i,
    input  cache_pkg::tid_t        fill_tid_i,

    output logic                   wr_en_o,
    output cache_pkg::be_t         wr_be_o,
    output cache_pkg::word_t       wr_data_o,

    output logic                   core_rsp_valid_o,
    output cache_pkg::word_t       core_rsp_rdata_o,
    output cache_pkg::tid_t        core_rsp_tid_o,

    output logic                   miss_valid_o,
    output cache_pkg::nline_t      miss_nline_o,
    output cache_pkg::tid_t        miss_tid_o,
    output cache_pkg::widx_t       miss_word_o,

    output logic                   mem_write_valid_o,
    output cache_pkg::addr_t       mem_write_addr_o,
    output cache_pkg::word_t       mem_write_data_o,
    output cache_pkg::be_t         mem_write_be_o
);

    logic is_load;
    logic is_store;
    logic load_hit;
    logic load_miss;

    // Request classification
    assign is_load   = s1_valid_i && !s1_is_store_i;
    assign is_store  = s1_valid_i && s1_is_store_i;
    assign load_hit  = is_load && hit_i;
    assign load_miss = is_load && !hit_i;

    // Write-through, no allocate: only a hit touches the array
    assign wr_en_o   = is_store && hit_i;
    assign wr_be_o   = s1_be_i;
    assign wr_data_o = s1_wdata_i;

    assign mem_write_valid_o = is_store;
    assign mem_write_addr_o  = s1_addr_i.addr;
    assign mem_write_data_o  = s1_wdata_i;
    assign mem_write_be_o    = s1_be_i;

    assign miss_valid_o = load_miss;
    assign miss_nline_o = {s1_addr_i.fields.tag, s1_addr_i.fields.set};
    assign miss_tid_o   = s1_tid_i;
    assign miss_word_o  = s1_addr_i.fields.word;

    // Refill response takes the port when present
    assign core_rsp_valid_o = load_hit || fill_valid_i;
    assign core_rsp_rdata_o = fill_valid_i ? fill_rdata_i : rd_word_i;
    assign core_rsp_tid_o   = fill_valid_i ? fill_tid_i : s1_tid_i;

    // Refill and request stages never present a response together
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(load_hit && fill_valid_i))
        else $error("hit_miss_ctrl: hit response and refill response together");

endmodule

`default_nettype wire

// ==== verilog/tag_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_data_array (
    input  logic                   clk_i,
    input  logic                   rst_ni,

    input  cache_pkg::cache_addr_u rd_addr_i,

    // Store word write, at the read address
    input  logic                   wr_en_i,
    input  cache_pkg::be_t         wr_be_i,
    input  cache_pkg::word_t       wr_data_i,

    // Refill line write
    input  logic                   fill_valid_i,
    input  cache_pkg::nline_t      fill_nline_i,
    input  cache_pkg::line_t       fill_line_i,

    output logic                   hit_o,
    output cache_pkg::word_t       rd_word_o
);
    import cache_pkg::*;

    logic  [NSETS-1:0] valid_q;
    tag_t              tag_q  [NSETS];
    word_t             data_q [NSETS][LINE_WORDS];

    set_t  rd_set;
    tag_t  rd_tag;
    widx_t rd_widx;
    set_t  fill_set;
    tag_t  fill_tag;

    assign rd_set   = rd_addr_i.fields.set;
    assign rd_tag   = rd_addr_i.fields.tag;
    assign rd_widx  = rd_addr_i.fields.word;
    assign fill_set = fill_nline_i[SET_W-1:0];
    assign fill_tag = fill_nline_i[NLINE_W-1:SET_W];

    // Lookup
    assign hit_o     = valid_q[rd_set] && (tag_q[rd_set] == rd_tag);
    assign rd_word_o = data_q[rd_set][rd_widx];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (fill_valid_i) begin
            valid_q[fill_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_valid_i) begin
            tag_q[fill_set] <= fill_tag;
            for (int w = 0; w < LINE_WORDS; w++) begin
                data_q[fill_set][w] <= fill_line_i[w*WORD_W +: WORD_W];
            end
        end else if (wr_en_i) begin
            // Byte merge into the cached word
            for (int b = 0; b < BE_W; b++) begin
                if (wr_be_i[b]) begin
                    data_q[rd_set][rd_widx][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // Store hits and refills come from different stages and must not meet
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(wr_en_i && fill_valid_i))
        else $error("tag_data_array: word write and line write together");

endmodule

`default_nettype wire

// ==== verilog/refill_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module refill_stage (
    input  logic              clk_i,
    input  logic              rst_ni,

    input  logic              refill_valid_i,
    input  cache_pkg::nline_t refill_nline_i,
    input  cache_pkg::tid_t   refill_tid_i,
    input  cache_pkg::widx_t  refill_word_i,
    input  cache_pkg::line_t  refill_line_i,

    // Only watched, see assertion below
    input  logic              core_req_valid_i,

    output logic              fill_valid_o,
    output cache_pkg::nline_t fill_nline_o,
    output cache_pkg::line_t  fill_line_o,
    output cache_pkg::tid_t   fill_tid_o,
    output cache_pkg::word_t  fill_rdata_o
);
    import cache_pkg::*;

    logic   fill_valid_q;
    nline_t fill_nline_q;
    line_t  fill_line_q;
    tid_t   fill_tid_q;
    widx_t  fill_word_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fill_valid_q <= 1'b0;
        end else begin
            fill_valid_q <= refill_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_valid_i) begin
            fill_nline_q <= refill_nline_i;
            fill_line_q  <= refill_line_i;
            fill_tid_q   <= refill_tid_i;
            fill_word_q  <= refill_word_i;
        end
    end

    assign fill_valid_o = fill_valid_q;
    assign fill_nline_o = fill_nline_q;
    assign fill_line_o  = fill_line_q;
    assign fill_tid_o   = fill_tid_q;

    // Word 0 sits in the low bits of the line
    assign fill_rdata_o = fill_line_q[fill_word_q*WORD_W +: WORD_W];

    // Core side and memory side never deliver in the same cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(refill_valid_i && core_req_valid_i))
        else $error("refill_stage: refill collides with core request");

endmodule

`default_nettype wire

// ==== verilog/req_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  core_req_valid_i,
    input  logic                  core_req_is_store_i,
    input  cache_pkg::addr_t      core_req_addr_i,
    input  cache_pkg::word_t      core_req_wdata_i,
    input  cache_pkg::be_t        core_req_be_i,
    input  cache_pkg::tid_t       core_req_tid_i,

    output logic                  s1_valid_o,
    output logic                  s1_is_store_o,
    output cache_pkg::cache_addr_u s1_addr_o,
    output cache_pkg::word_t      s1_wdata_o,
    output cache_pkg::be_t        s1_be_o,
    output cache_pkg::tid_t       s1_tid_o
);
    import cache_pkg::*;

    logic        s1_valid_q;
    logic        s1_is_store_q;
    cache_addr_u s1_addr_q;
    word_t       s1_wdata_q;
    be_t         s1_be_q;
    tid_t        s1_tid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= core_req_valid_i;
        end
    end

    // Payload only loads when a request is present
    always_ff @(posedge clk_i) begin
        if (core_req_valid_i) begin
            s1_is_store_q  <= core_req_is_store_i;
            s1_addr_q.addr <= core_req_addr_i;
            s1_wdata_q     <= core_req_wdata_i;
            s1_be_q        <= core_req_be_i;
            s1_tid_q       <= core_req_tid_i;
        end
    end

    assign s1_valid_o    = s1_valid_q;
    assign s1_is_store_o = s1_is_store_q;
    assign s1_addr_o     = s1_addr_q;
    assign s1_wdata_o    = s1_wdata_q;
    assign s1_be_o       = s1_be_q;
    assign s1_tid_o      = s1_tid_q;

    // A store arrives with at least one byte enabled
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (core_req_valid_i && core_req_is_store_i) |-> (core_req_be_i != '0))
        else $error("req_stage: store without byte enables");

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // Cache geometry: direct-mapped, 16 sets of four-word lines
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int BE_W       = WORD_W / 8;
    localparam int BYTE_IDX_W = 2;
    localparam int WORD_IDX_W = 2;
    localparam int SET_W      = 4;
    localparam int TAG_W      = ADDR_W - SET_W - WORD_IDX_W - BYTE_IDX_W;
    localparam int NLINE_W    = TAG_W + SET_W;
    localparam int LINE_WORDS = 1 << WORD_IDX_W;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int NSETS      = 1 << SET_W;
    localparam int TID_W      = 4;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BE_W-1:0]       be_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [SET_W-1:0]      set_t;
    typedef logic [WORD_IDX_W-1:0] widx_t;
    typedef logic [NLINE_W-1:0]    nline_t;
    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [TID_W-1:0]      tid_t;

    // Address split, tag in the upper bits
    typedef struct packed {
        tag_t                  tag;
        set_t                  set;
        widx_t                 word;
        logic [BYTE_IDX_W-1:0] byte_idx;
    } cache_addr_fields_t;

    // Same address word, flat or decoded
    typedef union packed {
        addr_t              addr;
        cache_addr_fields_t fields;
    } cache_addr_u;

endpackage

`default_nettype wire
